// ==== src/cachePkg.sv ====
`default_nettype none

package cachePkg;

    // processor side widths
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int BYTE_WIDTH = 8;

    // per-way use count, saturates instead of wrapping
    localparam int COUNT_WIDTH = 4;
    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = 4'd15;

    // size code on the processor port; unknown codes act as a word
    typedef enum logic [2:0] {
        accByte  = 3'b000,
        accHalf  = 3'b001,
        accWord  = 3'b010,
        accByteU = 3'b100,
        accHalfU = 3'b101
    } accessT;

    // miss handling: optional writeback, then refill
    typedef enum logic [2:0] {
        stIdle,
        stWbReq,
        stWbRel,
        stFillReq,
        stFillRel,
        stFillWrite
    } missStateT;

endpackage

`default_nettype wire

// ==== src/wayRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module wayRam #(
    parameter type payloadT = logic [31:0],
    parameter int DEPTH = 128,
    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input wire logic clk,
    input wire logic we,
    input wire logic [ADDR_BITS-1:0] addr,
    input wire payloadT wdata,
    output payloadT rdata
);

    // one entry per set
    payloadT mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read is combinational so a lookup completes in the request cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== src/wayStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module wayStore import cachePkg::*; #(
    parameter int LINE_BYTES = 8,
    parameter int NUM_SETS = 128,
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES),
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic [INDEX_WIDTH-1:0] index,
    input wire logic [TAG_WIDTH-1:0] tag,
    input wire logic fill,
    input wire logic [LINE_WIDTH-1:0] fillLine,
    input wire logic storeHit,
    input wire logic [LINE_WIDTH-1:0] storeLine,
    input wire logic [LINE_BYTES-1:0] storeMask,
    input wire logic useHit,
    output logic [LINE_WIDTH-1:0] lineOut,
    output logic [TAG_WIDTH-1:0] tagOut,
    output logic [COUNT_WIDTH-1:0] countOut,
    output logic validOut,
    output logic dirtyOut
);

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [COUNT_WIDTH-1:0] count;
    } tagEntryT;

    logic [NUM_SETS-1:0] validBits;
    logic [NUM_SETS-1:0] dirtyBits;
    logic [LINE_WIDTH-1:0] mergedLine;
    tagEntryT entryRd;
    tagEntryT entryWr;

    // only the lanes named by the mask take the store data
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            mergedLine[(LINE_BYTES-b)*BYTE_WIDTH-1 -: BYTE_WIDTH] = storeMask[b] ?
                storeLine[(LINE_BYTES-b)*BYTE_WIDTH-1 -: BYTE_WIDTH] :
                lineOut[(LINE_BYTES-b)*BYTE_WIDTH-1 -: BYTE_WIDTH];
        end
    end

    wayRam #(
        .payloadT(logic [LINE_WIDTH-1:0]),
        .DEPTH(NUM_SETS)
    ) uLineRam (
        .clk(clk),
        .we(fill || storeHit),
        .addr(index),
        .wdata(fill ? fillLine : mergedLine),
        .rdata(lineOut)
    );

    // new tag with a cleared count on fill, else bump the count
    always_comb begin
        if (fill) begin
            entryWr.tag = tag;
            entryWr.count = '0;
        end else begin
            entryWr.tag = entryRd.tag;
            entryWr.count = (entryRd.count == COUNT_MAX) ? entryRd.count :
                entryRd.count + 1'b1;
        end
    end

    wayRam #(
        .payloadT(tagEntryT),
        .DEPTH(NUM_SETS)
    ) uTagRam (
        .clk(clk),
        .we(fill || useHit),
        .addr(index),
        .wdata(entryWr),
        .rdata(entryRd)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (fill) begin
            validBits[index] <= 1'b1;
            dirtyBits[index] <= 1'b0;
        end else if (storeHit) begin
            dirtyBits[index] <= 1'b1;
        end
    end

    assign tagOut = entryRd.tag;
    assign countOut = entryRd.count;
    assign validOut = validBits[index];
    assign dirtyOut = dirtyBits[index];

endmodule

`default_nettype wire

// ==== src/hitDetect.sv ====
`timescale 1ns/1ps
`default_nettype none

module hitDetect import cachePkg::*; #(
    parameter int WAYS = 2,
    parameter int LINE_BYTES = 8,
    parameter int NUM_SETS = 128,
    localparam int WAY_WIDTH = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int TAG_WIDTH = ADDR_WIDTH - $clog2(LINE_BYTES) - $clog2(NUM_SETS)
) (
    input wire logic request,
    input wire logic [TAG_WIDTH-1:0] tag,
    input wire logic [WAYS-1:0] wayValid,
    input wire logic [TAG_WIDTH-1:0] wayTag [WAYS],
    input wire logic [COUNT_WIDTH-1:0] wayCount [WAYS],
    output logic [WAY_WIDTH-1:0] hitWay,
    output logic anyHit,
    output logic [WAY_WIDTH-1:0] victimWay
);

    logic [WAYS-1:0] hitVec;
    logic freeFound;
    logic [COUNT_WIDTH-1:0] minCount;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hitVec[w] = request && wayValid[w] && (wayTag[w] == tag);
        end
    end

    assign anyHit = |hitVec;

    // scan downwards so the lowest hitting index remains
    always_comb begin
        hitWay = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                hitWay = WAY_WIDTH'(w);
            end
        end
    end

    // first invalid way, else smallest use count; ties go to the lower way
    always_comb begin
        freeFound = 1'b0;
        victimWay = '0;
        minCount = COUNT_MAX;
        for (int w = 0; w < WAYS; w++) begin
            if (!freeFound && !wayValid[w]) begin
                freeFound = 1'b1;
                victimWay = WAY_WIDTH'(w);
            end
        end
        if (!freeFound) begin
            minCount = wayCount[0];
            for (int w = 1; w < WAYS; w++) begin
                if (wayCount[w] < minCount) begin
                    minCount = wayCount[w];
                    victimWay = WAY_WIDTH'(w);
                end
            end
        end
    end

    // a refill never installs a tag that another way of the set already holds
    oneWayHits: assert final (request !== 1'b1 || $onehot0(hitVec))
        else $error("more than one way hit for tag %h", tag);

endmodule

`default_nettype wire

// ==== src/accessAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessAlign import cachePkg::*; #(
    parameter int LINE_BYTES = 8,
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES),
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH,
    localparam int WORD_BYTES = WORD_WIDTH / BYTE_WIDTH
) (
    input wire logic [OFFSET_WIDTH-1:0] offset,
    input wire accessT size,
    input wire logic [LINE_WIDTH-1:0] line,
    input wire logic [WORD_WIDTH-1:0] writeData,
    output logic [WORD_WIDTH-1:0] loadData,
    output logic [LINE_WIDTH-1:0] storeLine,
    output logic [LINE_BYTES-1:0] storeMask
);

    logic [BYTE_WIDTH-1:0] lanes [LINE_BYTES];
    logic [BYTE_WIDTH-1:0] newLanes [LINE_BYTES];
    logic [OFFSET_WIDTH-1:0] halfBase;
    logic [OFFSET_WIDTH-1:0] wordBase;
    logic [BYTE_WIDTH-1:0] byteField;
    logic [2*BYTE_WIDTH-1:0] halfField;
    logic [WORD_WIDTH-1:0] wordField;

    // big-endian lanes, lane 0 holds the top byte of the line
    for (genvar b = 0; b < LINE_BYTES; b++) begin : gLane
        assign lanes[b] = line[(LINE_BYTES-b)*BYTE_WIDTH-1 -: BYTE_WIDTH];
        assign storeLine[(LINE_BYTES-b)*BYTE_WIDTH-1 -: BYTE_WIDTH] = newLanes[b];
    end

    // misaligned offsets are forced down to the natural boundary
    assign halfBase = offset & ~(OFFSET_WIDTH'(1));
    assign wordBase = offset & ~(OFFSET_WIDTH'(3));

    assign byteField = lanes[offset];
    assign halfField = {lanes[halfBase], lanes[halfBase + 1'b1]};
    assign wordField = {lanes[wordBase], lanes[wordBase + 2'd1],
                        lanes[wordBase + 2'd2], lanes[wordBase + 2'd3]};

    always_comb begin
        case (size)
            accByte: loadData = {{(WORD_WIDTH-BYTE_WIDTH){byteField[BYTE_WIDTH-1]}}, byteField};
            accByteU: loadData = {{(WORD_WIDTH-BYTE_WIDTH){1'b0}}, byteField};
            accHalf: loadData = {{(WORD_WIDTH-2*BYTE_WIDTH){halfField[2*BYTE_WIDTH-1]}},
                                 halfField};
            accHalfU: loadData = {{(WORD_WIDTH-2*BYTE_WIDTH){1'b0}}, halfField};
            default: loadData = wordField;
        endcase
    end

    // store field placed in its own lanes, the mask picks them out of the line
    // unsigned codes store like signed
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            newLanes[b] = '0;
        end
        storeMask = '0;
        case (size)
            accByte, accByteU: begin
                newLanes[offset] = writeData[BYTE_WIDTH-1:0];
                storeMask[offset] = 1'b1;
            end
            accHalf, accHalfU: begin
                newLanes[halfBase] = writeData[2*BYTE_WIDTH-1:BYTE_WIDTH];
                newLanes[halfBase + 1'b1] = writeData[BYTE_WIDTH-1:0];
                storeMask[halfBase] = 1'b1;
                storeMask[halfBase + 1'b1] = 1'b1;
            end
            default: begin
                for (int k = 0; k < WORD_BYTES; k++) begin
                    newLanes[wordBase + k] = writeData[WORD_WIDTH-1-k*BYTE_WIDTH -: BYTE_WIDTH];
                    storeMask[wordBase + k] = 1'b1;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/missControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module missControl import cachePkg::*; #(
    parameter int WAYS = 2,
    parameter int LINE_BYTES = 8,
    parameter int NUM_SETS = 128,
    localparam int WAY_WIDTH = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES),
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic read,
    input wire logic write,
    input wire logic anyHit,
    input wire logic [WAY_WIDTH-1:0] victimWay,
    input wire logic victimValid,
    input wire logic victimDirty,
    input wire logic [TAG_WIDTH-1:0] victimTag,
    input wire logic [LINE_WIDTH-1:0] victimLine,
    input wire logic [INDEX_WIDTH-1:0] index,
    input wire logic [ADDR_WIDTH-1:0] address,
    input wire logic memAck,
    input wire logic [LINE_WIDTH-1:0] memRdata,
    output logic memReq,
    output logic memWe,
    output logic [ADDR_WIDTH-1:0] memAddr,
    output logic [LINE_WIDTH-1:0] memWdata,
    output logic [WAY_WIDTH-1:0] fillWay,
    output logic fill,
    output logic [LINE_WIDTH-1:0] fillLine,
    output logic valid,
    output logic storeHit
);

    missStateT state;
    missStateT nextState;
    logic request;
    logic miss;
    logic [ADDR_WIDTH-1:0] wbAddr;
    logic [ADDR_WIDTH-1:0] fillAddr;

    assign request = read || write;
    assign miss = request && !anyHit;

    // victim line goes back under its own tag
    assign wbAddr = {victimTag, index, {OFFSET_WIDTH{1'b0}}};
    assign fillAddr = {address[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    // each request waits for ack high, then for ack low before moving on
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (miss) begin
                    nextState = (victimValid && victimDirty) ? stWbReq : stFillReq;
                end
            end
            stWbReq: begin
                if (memAck) begin
                    nextState = stWbRel;
                end
            end
            stWbRel: begin
                if (!memAck) begin
                    nextState = stFillReq;
                end
            end
            stFillReq: begin
                if (memAck) begin
                    nextState = stFillRel;
                end
            end
            stFillRel: begin
                if (!memAck) begin
                    nextState = stFillWrite;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    // victim way is frozen for the whole miss
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fillWay <= '0;
        end else if (state == stIdle && miss) begin
            fillWay <= victimWay;
        end
    end

    // refill data is only valid alongside the ack
    always_ff @(posedge clk) begin
        if (state == stFillReq && memAck) begin
            fillLine <= memRdata;
        end
    end

    assign memReq = (state == stWbReq) || (state == stFillReq);
    assign memWe = (state == stWbReq);
    assign memAddr = memWe ? wbAddr : fillAddr;
    assign memWdata = victimLine;

    assign fill = (state == stFillWrite);
    assign valid = (state == stIdle) && request && anyHit;
    assign storeHit = valid && write;

    // request held with stable address and direction until acknowledged
    reqHeld: assert property (@(posedge clk) disable iff (!rst)
        memReq && !memAck |=> memReq && $stable(memAddr) && $stable(memWe))
        else $error("memory request changed before ack");

endmodule

`default_nettype wire

// ==== src/dCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dCache import cachePkg::*; #(
    parameter int LINE_BYTES = 8,
    parameter int NUM_SETS = 128,
    parameter int WAYS = 2,
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic [ADDR_WIDTH-1:0] address,
    input wire logic read,
    input wire logic write,
    input wire logic [WORD_WIDTH-1:0] writeData,
    input wire accessT size,
    output logic [WORD_WIDTH-1:0] readData,
    output logic valid,
    output logic memReq,
    output logic memWe,
    output logic [ADDR_WIDTH-1:0] memAddr,
    output logic [LINE_WIDTH-1:0] memWdata,
    input wire logic memAck,
    input wire logic [LINE_WIDTH-1:0] memRdata
);

    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;
    localparam int WAY_WIDTH = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [OFFSET_WIDTH-1:0] offset;
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0] tag;
    logic request;
    logic [LINE_WIDTH-1:0] wayLine [WAYS];
    logic [TAG_WIDTH-1:0] wayTag [WAYS];
    logic [COUNT_WIDTH-1:0] wayCount [WAYS];
    logic [WAYS-1:0] wayValid;
    logic [WAYS-1:0] wayDirty;
    logic [WAY_WIDTH-1:0] hitWay;
    logic [WAY_WIDTH-1:0] victimWay;
    logic [WAY_WIDTH-1:0] fillWay;
    logic anyHit;
    logic fill;
    logic storeHit;
    logic [LINE_WIDTH-1:0] fillLine;
    logic [LINE_WIDTH-1:0] storeLine;
    logic [LINE_BYTES-1:0] storeMask;

    // tag | index | offset
    assign offset = address[OFFSET_WIDTH-1:0];
    assign index = address[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH];
    assign tag = address[ADDR_WIDTH-1:OFFSET_WIDTH+INDEX_WIDTH];
    assign request = read || write;

    for (genvar w = 0; w < WAYS; w++) begin : gWay
        wayStore #(
            .LINE_BYTES(LINE_BYTES),
            .NUM_SETS(NUM_SETS)
        ) uWay (
            .clk(clk),
            .rst(rst),
            .index(index),
            .tag(tag),
            .fill(fill && (fillWay == WAY_WIDTH'(w))),
            .fillLine(fillLine),
            .storeHit(storeHit && (hitWay == WAY_WIDTH'(w))),
            .storeLine(storeLine),
            .storeMask(storeMask),
            .useHit(valid && (hitWay == WAY_WIDTH'(w))),
            .lineOut(wayLine[w]),
            .tagOut(wayTag[w]),
            .countOut(wayCount[w]),
            .validOut(wayValid[w]),
            .dirtyOut(wayDirty[w])
        );
    end

    hitDetect #(
        .WAYS(WAYS),
        .LINE_BYTES(LINE_BYTES),
        .NUM_SETS(NUM_SETS)
    ) uHitDetect (
        .request(request),
        .tag(tag),
        .wayValid(wayValid),
        .wayTag(wayTag),
        .wayCount(wayCount),
        .hitWay(hitWay),
        .anyHit(anyHit),
        .victimWay(victimWay)
    );

    accessAlign #(
        .LINE_BYTES(LINE_BYTES)
    ) uAlign (
        .offset(offset),
        .size(size),
        .line(wayLine[hitWay]),
        .writeData(writeData),
        .loadData(readData),
        .storeLine(storeLine),
        .storeMask(storeMask)
    );

    // victim fields stay put during a miss since the set is untouched until refill
    missControl #(
        .WAYS(WAYS),
        .LINE_BYTES(LINE_BYTES),
        .NUM_SETS(NUM_SETS)
    ) uMissControl (
        .clk(clk),
        .rst(rst),
        .read(read),
        .write(write),
        .anyHit(anyHit),
        .victimWay(victimWay),
        .victimValid(wayValid[victimWay]),
        .victimDirty(wayDirty[victimWay]),
        .victimTag(wayTag[victimWay]),
        .victimLine(wayLine[victimWay]),
        .index(index),
        .address(address),
        .memAck(memAck),
        .memRdata(memRdata),
        .memReq(memReq),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .fillWay(fillWay),
        .fill(fill),
        .fillLine(fillLine),
        .valid(valid),
        .storeHit(storeHit)
    );

endmodule

`default_nettype wire

// ==== verification/cacheChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheChecker import cachePkg::*; #(
    parameter int LINE_BYTES = 8,
    parameter logic [7:0] FILL_XOR = 8'hA5,
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic [ADDR_WIDTH-1:0] address,
    input wire logic write,
    input wire logic [WORD_WIDTH-1:0] writeData,
    input wire accessT size,
    input wire logic [WORD_WIDTH-1:0] readData,
    input wire logic valid,
    input wire logic memReq,
    input wire logic memWe,
    input wire logic memAck,
    input wire logic [ADDR_WIDTH-1:0] memAddr,
    input wire logic [LINE_WIDTH-1:0] memWdata,
    input wire logic [WORD_WIDTH-1:0] expData,
    input wire logic expectHit,
    output int accessCount,
    output int errorCount,
    output int writebackCount
);

    // memory as the processor has written it so far
    logic [7:0] shadow [int unsigned];
    // lines that hold stores not yet written back
    bit dirtyLine [int unsigned];
    logic sawReq;
    bit released;

    function automatic logic [7:0] memoryByte(input logic [ADDR_WIDTH-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a[7:0] ^ FILL_XOR;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] expectedLine(input logic [ADDR_WIDTH-1:0] base);
        logic [LINE_WIDTH-1:0] line;
        for (int k = 0; k < LINE_BYTES; k++) begin
            line[(LINE_BYTES-k)*BYTE_WIDTH-1 -: BYTE_WIDTH] = memoryByte(base + k);
        end
        return line;
    endfunction

    // field aligned down to its size, most significant byte at the lowest address
    task automatic recordStore();
        int nBytes;
        logic [ADDR_WIDTH-1:0] base;
        if (size == accByte || size == accByteU) begin
            nBytes = 1;
        end else if (size == accHalf || size == accHalfU) begin
            nBytes = 2;
        end else begin
            nBytes = 4;
        end
        base = address & ~ADDR_WIDTH'(nBytes - 1);
        for (int k = 0; k < nBytes; k++) begin
            shadow[base + k] = writeData[(nBytes-k)*BYTE_WIDTH-1 -: BYTE_WIDTH];
        end
        dirtyLine[base & ~ADDR_WIDTH'(LINE_BYTES - 1)] = 1'b1;
    endtask

    task automatic checkWriteback();
        writebackCount++;
        if (!dirtyLine.exists(memAddr)) begin
            $display("CHECK FAILED at %0t: writeback of line %h, which holds no store",
                     $time, memAddr);
            errorCount++;
        end else begin
            dirtyLine.delete(memAddr);
        end
        if (memWdata !== expectedLine(memAddr)) begin
            $display("CHECK FAILED at %0t: writeback of line %h carries %h, expected %h",
                     $time, memAddr, memWdata, expectedLine(memAddr));
            errorCount++;
        end else begin
            $display("time %0t: writeback of line %h ok", $time, memAddr);
        end
    endtask

    task automatic completeAccess();
        accessCount++;
        if (expectHit && sawReq) begin
            $display("access %0d to %h went to memory although its line should be cached",
                     accessCount, address);
            errorCount++;
        end
        if (write) begin
            recordStore();
            $display("time %0t: access %0d stored %h at %h", $time, accessCount,
                     writeData, address);
        end else if (readData !== expData) begin
            $display("CHECK FAILED at %0t: load from %h returned %h, expected %h",
                     $time, address, readData, expData);
            errorCount++;
        end else begin
            $display("time %0t: access %0d load from %h returned %h ok", $time,
                     accessCount, address, readData);
        end
        sawReq = 1'b0;
    endtask

    initial begin
        accessCount = 0;
        errorCount = 0;
        writebackCount = 0;
        sawReq = 1'b0;
        released = 1'b0;
    end

    always @(posedge clk) begin
        if (rst === 1'b1 && !released) begin
            // first edge out of reset, no access is pending yet
            released = 1'b1;
            if (memReq !== 1'b0 || valid !== 1'b0) begin
                $display("CHECK FAILED at %0t: memReq or valid is not low right after reset",
                         $time);
                errorCount++;
            end else begin
                $display("time %0t: memReq and valid low after reset ok", $time);
            end
        end else if (rst === 1'b1) begin
            if (memReq === 1'b1) begin
                sawReq = 1'b1;
            end
            // a write is seen once, on the edge where the cache takes the ack
            if (memReq === 1'b1 && memWe === 1'b1 && memAck === 1'b1) begin
                checkWriteback();
            end
            if (valid === 1'b1) begin
                completeAccess();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/dCacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dCacheTb import cachePkg::*; ();

    localparam int LINE_BYTES = 8;
    localparam int NUM_SETS = 4;
    localparam int WAYS = 2;
    localparam int LINE_WIDTH = LINE_BYTES * BYTE_WIDTH;
    localparam logic [7:0] FILL_XOR = 8'hA5;
    localparam int MAX_LINES = 64;
    localparam int RESET_CYCLES = 10;
    // worst-case dirty miss with the longest ack wait
    localparam int CYCLES_PER_LINE = 20;

    logic clk;
    logic rst;
    logic [ADDR_WIDTH-1:0] address;
    logic read;
    logic write;
    logic [WORD_WIDTH-1:0] writeData;
    accessT size;
    logic [WORD_WIDTH-1:0] readData;
    logic valid;
    logic memReq;
    logic memWe;
    logic [ADDR_WIDTH-1:0] memAddr;
    logic [LINE_WIDTH-1:0] memWdata;
    logic memAck;
    logic [LINE_WIDTH-1:0] memRdata;
    logic [WORD_WIDTH-1:0] expData;
    logic expectHit;

    // five words per access: op, size, address, write data, expected load
    logic [31:0] stim [5*MAX_LINES];
    logic [7:0] memBytes [int unsigned];
    int unsigned lcgState;
    int numLines;
    int cycleCount;
    int cycleLimit = RESET_CYCLES + CYCLES_PER_LINE * MAX_LINES;
    int accessCount;
    int errorCount;
    int writebackCount;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    dCache #(
        .LINE_BYTES(LINE_BYTES),
        .NUM_SETS(NUM_SETS),
        .WAYS(WAYS)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .address(address),
        .read(read),
        .write(write),
        .writeData(writeData),
        .size(size),
        .readData(readData),
        .valid(valid),
        .memReq(memReq),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    cacheChecker #(
        .LINE_BYTES(LINE_BYTES),
        .FILL_XOR(FILL_XOR)
    ) uChecker (
        .clk(clk),
        .rst(rst),
        .address(address),
        .write(write),
        .writeData(writeData),
        .size(size),
        .readData(readData),
        .valid(valid),
        .memReq(memReq),
        .memWe(memWe),
        .memAck(memAck),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .expData(expData),
        .expectHit(expectHit),
        .accessCount(accessCount),
        .errorCount(errorCount),
        .writebackCount(writebackCount)
    );

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // untouched bytes follow the fill pattern
    function automatic logic [7:0] storedByte(input logic [ADDR_WIDTH-1:0] a);
        if (memBytes.exists(a)) begin
            return memBytes[a];
        end
        return a[7:0] ^ FILL_XOR;
    endfunction

    // lane 0 is the top byte and the lowest address
    function automatic logic [LINE_WIDTH-1:0] readLine(input logic [ADDR_WIDTH-1:0] base);
        logic [LINE_WIDTH-1:0] line;
        for (int k = 0; k < LINE_BYTES; k++) begin
            line[(LINE_BYTES-k)*BYTE_WIDTH-1 -: BYTE_WIDTH] = storedByte(base + k);
        end
        return line;
    endfunction

    task automatic writeLine(input logic [ADDR_WIDTH-1:0] base, input logic [LINE_WIDTH-1:0] line);
        for (int k = 0; k < LINE_BYTES; k++) begin
            memBytes[base + k] = line[(LINE_BYTES-k)*BYTE_WIDTH-1 -: BYTE_WIDTH];
        end
    endtask

    // four-phase memory, random wait before each ack
    always begin : memoryModel
        int waitCycles;
        @(posedge clk);
        if (memReq === 1'b1) begin
            waitCycles = nextRandom() % 6;
            repeat (waitCycles) @(posedge clk);
            #2;
            if (memWe) begin
                writeLine(memAddr, memWdata);
            end else begin
                memRdata = readLine(memAddr);
            end
            memAck = 1'b1;
            do begin
                @(posedge clk);
            end while (memReq === 1'b1);
            #2;
            memAck = 1'b0;
        end
    end

    // present one access and hold it until valid
    task automatic runAccess(input int i);
        logic [31:0] op;
        op = stim[5*i];
        address = stim[5*i+2];
        read = (op != 32'd1);
        write = (op == 32'd1);
        size = accessT'(stim[5*i+1][2:0]);
        writeData = stim[5*i+3];
        expData = stim[5*i+4];
        expectHit = (op == 32'd2);
        do begin
            @(posedge clk);
        end while (valid !== 1'b1);
        #2;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst = 1'b0;
        address = '0;
        read = 1'b0;
        write = 1'b0;
        writeData = '0;
        size = accWord;
        memAck = 1'b0;
        memRdata = '0;
        expData = '0;
        expectHit = 1'b0;
        lcgState = 56451;
        cycleCount = 0;
        $readmemh("verification/dCacheStim.txt", stim);
        numLines = 0;
        while (numLines < MAX_LINES && (stim[5*numLines] === 32'd0 ||
               stim[5*numLines] === 32'd1 || stim[5*numLines] === 32'd2)) begin
            numLines++;
        end
        if (numLines == 0) begin
            $display("no accesses could be read from the stimulus file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            cycleLimit = RESET_CYCLES + CYCLES_PER_LINE * numLines;
            repeat (RESET_CYCLES) @(posedge clk);
            #2 rst = 1'b1;
            // the checker looks at the idle outputs on this edge
            @(posedge clk);
            #2;
            for (int i = 0; i < numLines; i++) begin
                runAccess(i);
            end
            read = 1'b0;
            write = 1'b0;
            @(posedge clk);
            $display("accesses %0d, writebacks %0d, errors %0d", accessCount,
                     writebackCount, errorCount);
            if (errorCount == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/dCacheStim.txt ====
// op size address wdata expected, all hex
// op 0 load, 1 store, 2 load that must hit, 3 end; size 0 b, 1 h, 2 w, 4 bu, 5 hu
0 0 00000100 00000000 ffffffa5
0 4 00000101 00000000 000000a4
0 1 00000102 00000000 ffffa7a6
0 5 00000104 00000000 0000a1a0
0 2 00000104 00000000 a1a0a3a2
1 2 00000100 11223344 00000000
1 0 00000105 000000f0 00000000
1 1 00000106 00005566 00000000
0 2 00000104 00000000 a1f05566
0 0 00000105 00000000 fffffff0
0 5 00000102 00000000 00003344
0 0 00000101 00000000 00000022
0 2 00000120 00000000 85848786
0 2 00000140 00000000 e5e4e7e6
2 2 00000100 00000000 11223344
1 2 0000010c deadbeef 00000000
0 2 00000128 00000000 8d8c8f8e
2 2 00000128 00000000 8d8c8f8e
0 5 0000012e 00000000 00008b8a
0 2 00000148 00000000 edecefee
2 2 00000128 00000000 8d8c8f8e
0 2 0000010c 00000000 deadbeef
0 0 0000010d 00000000 ffffffad
3 0 00000000 00000000 00000000

// ==== sim.f ====
src/cachePkg.sv
src/wayRam.sv
src/wayStore.sv
src/hitDetect.sv
src/accessAlign.sv
src/missControl.sv
src/dCache.sv
verification/cacheChecker.sv
verification/dCacheTb.sv
